/* x86_reg_pkg.sv */
`default_nettype none

package x86_reg_pkg;

  // ******************************
  // Register file geometry
  // ******************************

  // Read ports and writeback slots per cycle
  localparam int NUM_RD = 4;
  localparam int NUM_WB = 3;

  typedef logic [2:0] reg_idx_t;

  // Physical order, same as the ModR/M reg encoding
  localparam reg_idx_t REG_EAX = 3'd0;
  localparam reg_idx_t REG_ECX = 3'd1;
  localparam reg_idx_t REG_EDX = 3'd2;
  localparam reg_idx_t REG_EBX = 3'd3;
  localparam reg_idx_t REG_ESP = 3'd4;
  localparam reg_idx_t REG_EBP = 3'd5;
  localparam reg_idx_t REG_ESI = 3'd6;
  localparam reg_idx_t REG_EDI = 3'd7;

  // ******************************
  // Operand size and field views
  // ******************************

  typedef enum logic [1:0] {
    SZ_BYTE,
    SZ_WORD,
    SZ_DWORD
  } opsize_e;

  // 8-bit naming, hi set means AH/CH/DH/BH (byte 1 of reg 0..3)
  typedef struct packed {
    logic       hi;
    logic [1:0] lo;
  } byte_sel_t;

  // Same 3 bits, read as a full index or as a byte selector
  typedef union packed {
    reg_idx_t  full;
    byte_sel_t bsel;
  } reg_field_u;

  // ******************************
  // Stack engine
  // ******************************

  typedef enum logic [1:0] {
    STK_NONE,
    STK_PUSH,
    STK_POP
  } stack_op_e;

  // ESP moves by one dword per push or pop
  localparam logic [31:0] STACK_STEP = 32'd4;

endpackage

`default_nettype wire

/* regacc_pkg.sv */
`default_nettype none

package regacc_pkg;

  import x86_reg_pkg::*;

  // ******************************
  // Operand specifier
  // ******************************

  typedef struct packed {
    reg_field_u field;
    opsize_e    size;
  } operand_t;

  // ******************************
  // Read channel
  // ******************************

  // Four operands plus an optional stack op
  typedef struct packed {
    operand_t [NUM_RD-1:0] opnd;
    stack_op_e             stack;
  } rd_req_t;

  // Zero-extended operand values and the stack address
  typedef struct packed {
    logic [NUM_RD-1:0][31:0] val;
    logic [31:0]             stack_addr;
  } rd_rsp_t;

  // ******************************
  // Write channel
  // ******************************

  typedef struct packed {
    logic        en;
    operand_t    opnd;
    logic [31:0] data;
  } wb_slot_t;

  typedef struct packed {
    wb_slot_t [NUM_WB-1:0] slot;
  } wb_bundle_t;

  // Physical write port, data already placed in its byte lanes
  typedef struct packed {
    logic        en;
    reg_idx_t    idx;
    logic [3:0]  strb;
    logic [31:0] data;
  } wr_port_t;

endpackage

`default_nettype wire

/* regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module regfile
  import x86_reg_pkg::*;
  import regacc_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  reg_idx_t [NUM_RD-1:0]   rd_idx,
  output logic [NUM_RD-1:0][31:0] rd_data,
  input  wr_port_t                wr_port1,
  input  wr_port_t                wr_port2,
  input  wr_port_t                wr_port3,
  output logic [31:0]             esp
);

  logic [31:0] regs [8];

  // Port 1 at index 0, port 3 at the top
  wr_port_t [NUM_WB-1:0] wr_ports;

  assign wr_ports = {wr_port3, wr_port2, wr_port1};

  // ******************************
  // Read ports
  // ******************************

  always_comb begin
    for (int i = 0; i < NUM_RD; i++) begin
      rd_data[i] = regs[rd_idx[i]];
    end
  end

  // Stack engine tap
  assign esp = regs[REG_ESP];

  // ******************************
  // Write ports
  // ******************************

  // Ports are visited in rising order, so for a shared lane
  // the last matching port (the highest number) lands
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < 8; r++) begin
        regs[r] <= '0;
      end
    end else begin
      for (int r = 0; r < 8; r++) begin
        for (int b = 0; b < 4; b++) begin
          for (int p = 0; p < NUM_WB; p++) begin
            if (wr_ports[p].en && wr_ports[p].idx == reg_idx_t'(r) &&
                wr_ports[p].strb[b]) begin
              regs[r][8*b +: 8] <= wr_ports[p].data[8*b +: 8];
            end
          end
        end
      end
    end
  end

  // ******************************
  // Checks
  // ******************************

  // An enabled port must touch at least one lane
  for (genvar p = 0; p < NUM_WB; p++) begin : g_strb_chk
    assert property (@(posedge clk) disable iff (rst)
      wr_ports[p].en |-> wr_ports[p].strb != 4'b0000)
      else $error("write port %0d enabled with empty strobe", p + 1);
  end

endmodule

`default_nettype wire

/* wb_format.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_format
  import x86_reg_pkg::*;
  import regacc_pkg::*;
(
  input  wb_slot_t slot,
  output wr_port_t port
);

  logic [7:0] low_byte;

  assign low_byte = slot.data[7:0];

  always_comb begin
    // Dword write by default
    port.en   = slot.en;
    port.idx  = slot.opnd.field.full;
    port.strb = 4'b1111;
    port.data = slot.data;

    case (slot.opnd.size)
      SZ_BYTE: begin
        // AL..BL or AH..BH of registers 0 to 3
        port.idx = {1'b0, slot.opnd.field.bsel.lo};
        if (slot.opnd.field.bsel.hi) begin
          port.strb = 4'b0010;
          port.data = {16'h0000, low_byte, 8'h00};
        end else begin
          port.strb = 4'b0001;
          port.data = {24'h000000, low_byte};
        end
      end
      SZ_WORD: begin
        port.strb = 4'b0011;
        port.data = {16'h0000, slot.data[15:0]};
      end
      SZ_DWORD: begin
        port.strb = 4'b1111;
      end
      default: begin
        // Unused size code, treated as dword
        port.strb = 4'b1111;
      end
    endcase
  end

endmodule

`default_nettype wire

/* rd_extract.sv */
`timescale 1ns/10ps
`default_nettype none

module rd_extract
  import x86_reg_pkg::*;
  import regacc_pkg::*;
(
  input  operand_t    opnd,
  output reg_idx_t    rd_idx,
  input  logic [31:0] raw,
  output logic [31:0] value
);

  // Byte selectors only reach registers 0 to 3
  assign rd_idx = (opnd.size == SZ_BYTE) ? {1'b0, opnd.field.bsel.lo}
                                         : opnd.field.full;

  // Zero extension for the narrow sizes
  always_comb begin
    case (opnd.size)
      SZ_BYTE: begin
        if (opnd.field.bsel.hi) begin
          value = {24'h000000, raw[15:8]};
        end else begin
          value = {24'h000000, raw[7:0]};
        end
      end
      SZ_WORD: begin
        value = {16'h0000, raw[15:0]};
      end
      default: begin
        value = raw;
      end
    endcase
  end

endmodule

`default_nettype wire

/* regacc_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module regacc_ctrl
  import x86_reg_pkg::*;
  import regacc_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  stack_op_e               rd_stack,
  input  logic                    rd_valid,
  output logic                    rd_ready,
  input  logic [NUM_RD-1:0][31:0] opnd_val,
  output rd_rsp_t                 rsp,
  output logic                    rsp_valid,
  input  logic                    rsp_ready,
  input  logic                    wb_valid,
  output logic                    wb_ready,
  input  wr_port_t [NUM_WB-1:0]   wb_ports,
  input  logic [31:0]             esp,
  output wr_port_t                wr_port1,
  output wr_port_t                wr_port2,
  output wr_port_t                wr_port3
);

  logic        rd_fire;
  logic        stk_fire;
  logic        wb_fire;
  logic [31:0] esp_new;
  logic [31:0] stack_addr;
  wr_port_t    stk_port;
  wr_port_t    slot3_port;

  // ******************************
  // Handshakes
  // ******************************

  // One response in flight, refilled as soon as it drains
  assign rd_ready = !rsp_valid || rsp_ready;
  assign rd_fire  = rd_valid && rd_ready;
  assign stk_fire = rd_fire && (rd_stack != STK_NONE);

  // Port 3 belongs to the stack engine when both want it
  assign wb_ready = !(stk_fire && wb_ports[2].en);
  assign wb_fire  = wb_valid && wb_ready;

  // ******************************
  // Stack engine
  // ******************************

  always_comb begin
    case (rd_stack)
      STK_PUSH: begin
        esp_new    = esp - STACK_STEP;
        stack_addr = esp_new;
      end
      STK_POP: begin
        esp_new    = esp + STACK_STEP;
        stack_addr = esp;
      end
      default: begin
        esp_new    = esp;
        stack_addr = esp;
      end
    endcase
  end

  always_comb begin
    stk_port      = '0;
    stk_port.en   = stk_fire;
    stk_port.idx  = REG_ESP;
    stk_port.strb = 4'b1111;
    stk_port.data = esp_new;
  end

  // ******************************
  // Write port steering
  // ******************************

  always_comb begin
    wr_port1       = wb_ports[0];
    wr_port1.en    = wb_ports[0].en && wb_fire;
    wr_port2       = wb_ports[1];
    wr_port2.en    = wb_ports[1].en && wb_fire;
    slot3_port     = wb_ports[2];
    slot3_port.en  = wb_ports[2].en && wb_fire;
  end

  assign wr_port3 = stk_fire ? stk_port : slot3_port;

  // ******************************
  // Response register
  // ******************************

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
    end else if (rd_fire) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  // Captures the register state before this edge's writes
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rsp.val        <= opnd_val;
      rsp.stack_addr <= stack_addr;
    end
  end

  // ******************************
  // Checks
  // ******************************

  assert property (@(posedge clk) disable iff (rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else $error("response changed while stalled");

  assert property (@(posedge clk) disable iff (rst)
    !(stk_fire && slot3_port.en))
    else $error("stack update and slot 3 both on write port 3");

endmodule

`default_nettype wire

/* reg_access_top.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_access_top
  import x86_reg_pkg::*;
  import regacc_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  rd_req_t    rd_req,
  input  logic       rd_valid,
  output logic       rd_ready,
  output rd_rsp_t    rsp,
  output logic       rsp_valid,
  input  logic       rsp_ready,
  input  wb_bundle_t wb,
  input  logic       wb_valid,
  output logic       wb_ready
);

  reg_idx_t [NUM_RD-1:0]   rd_idx;
  logic [NUM_RD-1:0][31:0] rd_raw;
  logic [NUM_RD-1:0][31:0] opnd_val;
  wr_port_t [NUM_WB-1:0]   wb_ports;
  wr_port_t                wr_port1;
  wr_port_t                wr_port2;
  wr_port_t                wr_port3;
  logic [31:0]             esp;

  // ******************************
  // Operand formatting
  // ******************************

  for (genvar i = 0; i < NUM_RD; i++) begin : g_rd
    rd_extract rd_extract_i (
      .opnd   (rd_req.opnd[i]),
      .rd_idx (rd_idx[i]),
      .raw    (rd_raw[i]),
      .value  (opnd_val[i])
    );
  end

  for (genvar i = 0; i < NUM_WB; i++) begin : g_wb
    wb_format wb_format_i (
      .slot (wb.slot[i]),
      .port (wb_ports[i])
    );
  end

  // ******************************
  // Control and storage
  // ******************************

  regacc_ctrl regacc_ctrl_i (
    .clk       (clk),
    .rst       (rst),
    .rd_stack  (rd_req.stack),
    .rd_valid  (rd_valid),
    .rd_ready  (rd_ready),
    .opnd_val  (opnd_val),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .wb_valid  (wb_valid),
    .wb_ready  (wb_ready),
    .wb_ports  (wb_ports),
    .esp       (esp),
    .wr_port1  (wr_port1),
    .wr_port2  (wr_port2),
    .wr_port3  (wr_port3)
  );

  regfile regfile_i (
    .clk      (clk),
    .rst      (rst),
    .rd_idx   (rd_idx),
    .rd_data  (rd_raw),
    .wr_port1 (wr_port1),
    .wr_port2 (wr_port2),
    .wr_port3 (wr_port3),
    .esp      (esp)
  );

endmodule

`default_nettype wire

/* tb_reg_access.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_reg_access
  import x86_reg_pkg::*;
  import regacc_pkg::*;
();

  // Limit is four times the roughly 500 cycles the tests take
  localparam int EXPECTED_CYCLES = 500;
  localparam int CYCLE_LIMIT     = 4 * EXPECTED_CYCLES;

  typedef struct packed {
    rd_rsp_t rsp;
    logic    chk_addr;
  } exp_t;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  rd_req_t     rd_req = '0;
  logic        rd_valid = 1'b0;
  logic        rd_ready;
  rd_rsp_t     rsp;
  logic        rsp_valid;
  logic        rsp_ready = 1'b1;
  wb_bundle_t  wb = '0;
  logic        wb_valid = 1'b0;
  logic        wb_ready;
  logic        wb_ready_exp;
  integer      seed = 32'h8380;
  // Separate stream for the stall pattern
  integer      stall_seed = 32'h8380 ^ 32'h0000ffff;
  logic        stall_mode = 1'b0;
  int          cycles = 0;
  int          errors = 0;
  int          test_errors = 0;
  int          read_count = 0;
  int          rsp_count = 0;
  int          exp_cnt = 0;
  logic        rd_fire_n = 1'b0;
  logic        wb_fire_n = 1'b0;
  logic        rsp_fire_n = 1'b0;
  logic        seen_read = 1'b0;
  logic [31:0] model_regs [8];
  exp_t        exp_q [$];
  exp_t        exp_head = '0;
  exp_t        new_exp;
  logic [31:0] new_esp;

  reg_access_top reg_access_top_i (
    .clk       (clk),
    .rst       (rst),
    .rd_req    (rd_req),
    .rd_valid  (rd_valid),
    .rd_ready  (rd_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .wb        (wb),
    .wb_valid  (wb_valid),
    .wb_ready  (wb_ready)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  always @(posedge clk) begin
    #0.5;
    rsp_ready = stall_mode ? ($random(stall_seed) % 2 != 0) : 1'b1;
  end

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Mismatch %s: got %h expected %h", sig, got, exp);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("Failure: %s", what);
    errors++;
  endtask

  // ******************************
  // Reference model
  // ******************************

  function automatic logic [31:0] operand_value(input operand_t o);
    logic [2:0]  f;
    logic [31:0] r;
    f = o.field.full;
    r = model_regs[{1'b0, f[1:0]}];
    case (o.size)
      SZ_BYTE:  return f[2] ? {24'h0, r[15:8]} : {24'h0, r[7:0]};
      SZ_WORD:  return {16'h0, model_regs[f][15:0]};
      default:  return model_regs[f];
    endcase
  endfunction

  function automatic void apply_slot(input wb_slot_t s);
    logic [2:0] f;
    f = s.opnd.field.full;
    if (!s.en) return;
    case (s.opnd.size)
      SZ_BYTE: begin
        if (f[2]) model_regs[f[1:0]][15:8] = s.data[7:0];
        else model_regs[f[1:0]][7:0] = s.data[7:0];
      end
      SZ_WORD: model_regs[f][15:0] = s.data[15:0];
      default: model_regs[f] = s.data;
    endcase
  endfunction

  // Sample the coming edge's transfers at the falling edge
  always @(negedge clk) begin
    rd_fire_n  = !rst && rd_valid && rd_ready;
    wb_fire_n  = !rst && wb_valid && wb_ready;
    rsp_fire_n = !rst && rsp_valid && rsp_ready;
  end

  always @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < 8; r++) model_regs[r] = '0;
      exp_q.delete();
    end else begin
      if (rsp_fire_n) begin
        rsp_count++;
        if (exp_q.size() != 0) void'(exp_q.pop_front());
      end
      new_esp = model_regs[REG_ESP];
      if (rd_fire_n) begin
        for (int i = 0; i < NUM_RD; i++) new_exp.rsp.val[i] = operand_value(rd_req.opnd[i]);
        new_exp.chk_addr = 1'b1;
        case (rd_req.stack)
          STK_PUSH: begin
            new_esp = model_regs[REG_ESP] - 32'd4;
            new_exp.rsp.stack_addr = new_esp;
          end
          STK_POP: begin
            new_esp = model_regs[REG_ESP] + 32'd4;
            new_exp.rsp.stack_addr = model_regs[REG_ESP];
          end
          default: begin
            new_exp.chk_addr = 1'b0;
            new_exp.rsp.stack_addr = '0;
          end
        endcase
        exp_q.push_back(new_exp);
        read_count++;
        seen_read = 1'b1;
      end
      // Slot 3 applied last among the slots and the ESP update after it
      if (wb_fire_n) for (int s = 0; s < NUM_WB; s++) apply_slot(wb.slot[s]);
      if (rd_fire_n && rd_req.stack != STK_NONE) model_regs[REG_ESP] = new_esp;
    end
    exp_cnt  = exp_q.size();
    exp_head = (exp_cnt != 0) ? exp_q[0] : '0;
  end

  // Writebacks stall only for a stack read that takes port 3 from slot 3
  assign wb_ready_exp = !(rd_valid && (!rsp_valid || rsp_ready) &&
                          rd_req.stack != STK_NONE && wb.slot[2].en);

  // ******************************
  // Checks
  // ******************************

  for (genvar i = 0; i < NUM_RD; i++) begin : g_val_chk
    assert property (@(posedge clk) disable iff (rst)
      rsp_valid && rsp_ready && exp_cnt != 0 |-> rsp.val[i] == exp_head.rsp.val[i])
      else report_mismatch($sformatf("rsp.val[%0d]", i), $sampled(rsp.val[i]),
                           $sampled(exp_head.rsp.val[i]));
  end

  assert property (@(posedge clk) disable iff (rst)
    rsp_valid && rsp_ready && exp_cnt != 0 && exp_head.chk_addr |->
      rsp.stack_addr == exp_head.rsp.stack_addr)
    else report_mismatch("rsp.stack_addr", $sampled(rsp.stack_addr),
                         $sampled(exp_head.rsp.stack_addr));

  assert property (@(posedge clk) disable iff (rst) rsp_valid && rsp_ready |-> exp_cnt != 0)
    else report_failure("a response arrived with no read outstanding");

  assert property (@(posedge clk) disable iff (rst) !seen_read |-> !rsp_valid)
    else report_failure("rsp_valid went high before any read was accepted");

  assert property (@(posedge clk) disable iff (rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else report_failure("the response changed or vanished while stalled");

  assert property (@(posedge clk) disable iff (rst) rd_ready == (!rsp_valid || rsp_ready))
    else report_mismatch("rd_ready", $sampled(rd_ready), $sampled(!rsp_valid || rsp_ready));

  assert property (@(posedge clk) disable iff (rst) wb_ready == wb_ready_exp)
    else report_mismatch("wb_ready", $sampled(wb_ready), $sampled(wb_ready_exp));

  // ******************************
  // Stimulus
  // ******************************

  function automatic operand_t make_opnd(input logic [2:0] f, input opsize_e sz);
    operand_t o;
    o.field.full = f;
    o.size = sz;
    return o;
  endfunction

  function automatic rd_req_t make_req(input operand_t a, b, c, d, input stack_op_e op);
    rd_req_t r;
    r.opnd = {d, c, b, a};
    r.stack = op;
    return r;
  endfunction

  function automatic operand_t rand_operand(input logic low_regs);
    logic [2:0] f;
    opsize_e    sz;
    f  = 3'($random(seed));
    sz = opsize_e'($unsigned($random(seed)) % 3);
    if (low_regs && sz != SZ_BYTE) f[2] = 1'b0;
    return make_opnd(f, sz);
  endfunction

  function automatic wb_bundle_t rand_bundle(input logic all_en);
    wb_bundle_t b;
    for (int s = 0; s < NUM_WB; s++) begin
      b.slot[s].en   = all_en || ($random(seed) % 2 != 0);
      b.slot[s].opnd = rand_operand(1'b1);
      b.slot[s].data = $random(seed);
    end
    return b;
  endfunction

  function automatic wb_bundle_t one_write(input logic [2:0] f, input opsize_e sz,
                                           input logic [31:0] data);
    wb_bundle_t b;
    b = '0;
    b.slot[0] = '{en: 1'b1, opnd: make_opnd(f, sz), data: data};
    return b;
  endfunction

  task automatic send_read(input rd_req_t req);
    rd_req = req;
    rd_valid = 1'b1;
    @(posedge clk);
    while (!rd_fire_n) @(posedge clk);
    #0.5;
    rd_valid = 1'b0;
  endtask

  task automatic send_wb(input wb_bundle_t b);
    wb = b;
    wb_valid = 1'b1;
    @(posedge clk);
    while (!wb_fire_n) @(posedge clk);
    #0.5;
    wb_valid = 1'b0;
  endtask

  task automatic read_dwords(input logic [2:0] base, input stack_op_e op);
    send_read(make_req(make_opnd(base, SZ_DWORD), make_opnd(base + 3'd1, SZ_DWORD),
                       make_opnd(base + 3'd2, SZ_DWORD), make_opnd(base + 3'd3, SZ_DWORD), op));
  endtask

  task automatic end_test(input int num, input string name);
    @(negedge clk);
    while (exp_cnt != 0 || rsp_valid) @(negedge clk);
    repeat (2) @(posedge clk);
    #0.5;
    if (errors == test_errors) $display("test %0d %s: ok", num, name);
    else $display("test %0d %s: %0d errors", num, name, errors - test_errors);
    test_errors = errors;
  endtask

  initial begin
    rd_req_t    req;
    wb_bundle_t b;
    repeat (4) @(posedge clk);
    #0.5;
    rst = 1'b0;
    repeat (2) @(posedge clk);
    #0.5;

    // All names at all sizes including AL..BH
    for (int s = 0; s < 3; s++) begin
      for (int h = 0; h < 8; h += 4) begin
        send_read(make_req(make_opnd(3'(h), opsize_e'(s)), make_opnd(3'(h + 1), opsize_e'(s)),
                           make_opnd(3'(h + 2), opsize_e'(s)), make_opnd(3'(h + 3), opsize_e'(s)),
                           STK_NONE));
      end
    end
    end_test(1, "reset values");

    for (int r = 0; r < 8; r += 3) begin
      for (int s = 0; s < NUM_WB; s++) begin
        b.slot[s] = '{en: (r + s < 8), opnd: make_opnd(3'(r + s), SZ_DWORD), data: $random(seed)};
      end
      send_wb(b);
    end
    read_dwords(3'd0, STK_NONE);
    read_dwords(3'd4, STK_NONE);
    // Read right behind the write
    for (int k = 0; k < 3; k++) begin
      send_wb(one_write(3'(5 + k), SZ_DWORD, $random(seed)));
      read_dwords(3'd4, STK_NONE);
    end
    end_test(2, "dword write and read");

    send_wb(one_write(REG_EAX, SZ_DWORD, 32'h11223344));
    send_wb(one_write(3'd0, SZ_BYTE, 32'h000000aa));
    send_wb(one_write(3'd4, SZ_BYTE, 32'h000000bb));
    read_dwords(3'd0, STK_NONE);
    send_wb(one_write(REG_EAX, SZ_WORD, 32'hffff5a69));
    send_wb(one_write(REG_ECX, SZ_WORD, 32'hffffccdd));
    send_wb(one_write(REG_EDX, SZ_DWORD, 32'h5566a788));
    send_wb(one_write(3'd7, SZ_BYTE, 32'h0000007e));
    read_dwords(3'd0, STK_NONE);
    send_read(make_req(make_opnd(3'd4, SZ_BYTE), make_opnd(3'd5, SZ_BYTE),
                       make_opnd(3'd6, SZ_BYTE), make_opnd(3'd7, SZ_BYTE), STK_NONE));
    send_read(make_req(make_opnd(3'd0, SZ_WORD), make_opnd(3'd1, SZ_WORD),
                       make_opnd(3'd0, SZ_BYTE), make_opnd(3'd2, SZ_BYTE), STK_NONE));
    end_test(3, "byte and word lanes");

    for (int k = 0; k < 40; k++) begin
      send_wb(rand_bundle(1'b1));
      read_dwords(3'd0, STK_NONE);
    end
    end_test(4, "write slot priority");

    send_wb(one_write(REG_ESP, SZ_DWORD, 32'h00001000));
    repeat (3) read_dwords(3'd4, STK_PUSH);
    repeat (2) read_dwords(3'd4, STK_POP);
    // Push and slot 3 in the same cycle
    b = rand_bundle(1'b1);
    b.slot[2].opnd = make_opnd(REG_EBP, SZ_DWORD);
    fork
      read_dwords(3'd4, STK_PUSH);
      send_wb(b);
    join
    read_dwords(3'd4, STK_POP);
    read_dwords(3'd4, STK_NONE);
    end_test(5, "push and pop");

    stall_mode = 1'b1;
    for (int k = 0; k < 60; k++) begin
      req = make_req(rand_operand(1'b0), rand_operand(1'b0), rand_operand(1'b0),
                     rand_operand(1'b0), stack_op_e'($unsigned($random(seed)) % 3));
      b = rand_bundle(1'b0);
      if ($random(seed) % 2 != 0) begin
        fork
          send_read(req);
          send_wb(b);
        join
      end else begin
        send_read(req);
      end
    end
    stall_mode = 1'b0;
    end_test(6, "response stalls");

    if (read_count != rsp_count) report_failure("responses received differ from reads accepted");
    $display("tests 6, reads %0d, responses %0d, errors %0d", read_count, rsp_count, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
x86_reg_pkg.sv
regacc_pkg.sv
regfile.sv
wb_format.sv
rd_extract.sv
regacc_ctrl.sv
reg_access_top.sv
tb_reg_access.sv
